//--- list.f
source/ahb_pkg.sv
source/ahb_slave_if.sv
source/ahb_ram.sv
source/ahb_pio.sv
source/ahb_interconnect.sv
source/ahb_subsystem.sv
tests/ahb_subsystem_tb.sv

//--- source/ahb_interconnect.sv
`timescale 1ns/1ns

// Single-master AHB-Lite interconnect for two slaves.
// Decoding is done on the address phase and a register remembers who owns the data phase.
module ahb_interconnect import ahb_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  htrans_t htrans,
    input  hsize_t  hsize,
    input  logic    hwrite,
    input  addr_t   haddr,
    input  data_t   hwdata,
    output data_t   hrdata,
    output logic    hready,
    output logic    hresp,
    ahb_slave_if.manager ram_bus,
    ahb_slave_if.manager pio_bus
);

    // Owner of the current data phase.
    typedef enum logic [1:0] {
        SEL_NONE,
        SEL_RAM,
        SEL_PIO
    } sel_e;

    region_t region;    // Top nibble of the address.
    logic    ram_hit;
    logic    pio_hit;
    logic    active;    // NONSEQ or SEQ on the master port.
    sel_e    addr_sel;  // Owner of the next data phase.
    sel_e    data_sel;  // Owner of the current data phase.

    assign region  = haddr[31:28];
    assign ram_hit = (region == RAM_REGION);
    assign pio_hit = (region == PIO_REGION);
    assign active  = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);

    // Select lines are plain address decode. The slaves qualify them with htrans.
    assign ram_bus.hsel = ram_hit;
    assign pio_bus.hsel = pio_hit;

    // Both slaves see the same request signals.
    assign ram_bus.htrans    = htrans;
    assign ram_bus.hsize     = hsize;
    assign ram_bus.hwrite    = hwrite;
    assign ram_bus.haddr     = haddr;
    assign ram_bus.hwdata    = hwdata;
    assign ram_bus.hready_in = hready;
    assign pio_bus.htrans    = htrans;
    assign pio_bus.hsize     = hsize;
    assign pio_bus.hwrite    = hwrite;
    assign pio_bus.haddr     = haddr;
    assign pio_bus.hwdata    = hwdata;
    assign pio_bus.hready_in = hready;

    // Idle, busy and unmapped transfers give a data phase with no owner.
    always_comb begin
        addr_sel = SEL_NONE;
        if (active && ram_hit) addr_sel = SEL_RAM;
        else if (active && pio_hit) addr_sel = SEL_PIO;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            data_sel <= SEL_NONE;
        end else if (hready) begin
            data_sel <= addr_sel;   // Held while a slave stretches its data phase.
        end
    end

    // Response mux. With no owner the master gets ready and zero data.
    always_comb begin
        case (data_sel)
            SEL_RAM: begin
                hready = ram_bus.hready_out;
                hrdata = ram_bus.hrdata;
            end
            SEL_PIO: begin
                hready = pio_bus.hready_out;
                hrdata = pio_bus.hrdata;
            end
            default: begin
                hready = 1'b1;
                hrdata = '0;
            end
        endcase
    end

    assign hresp = HRESP_OKAY;  // Error responses are never raised.

endmodule

//--- source/ahb_pio.sv
`timescale 1ns/1ns

// Parallel output register on the bus.
// Writes merge their enabled byte lanes into pio. Reads are not supported and return zero.
module ahb_pio import ahb_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    ahb_slave_if.slave bus,
    output data_t      pio
);

    logic  wr_accept;   // A write address phase for this slave this cycle.
    logic  wr_valid_q;  // A captured write is in its data phase.
    strb_t lanes_q;     // Its byte lanes.

    assign wr_accept = bus.hsel && bus.hwrite
                    && ((bus.htrans == HTRANS_NONSEQ) || (bus.htrans == HTRANS_SEQ))
                    && bus.hready_in;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_valid_q <= 1'b0;
        end else if (bus.hready_in) begin
            wr_valid_q <= wr_accept;
        end
    end

    // Lane enables follow the address phase that was captured with them.
    always_ff @(posedge clk) begin
        if (bus.hready_in) begin
            lanes_q <= byte_lanes(bus.hsize, bus.haddr[1:0]);
        end
    end

    // The output register. Untouched lanes keep their old value.
    always_ff @(posedge clk) begin
        if (reset) begin
            pio <= '0;
        end else if (wr_valid_q && bus.hready_in) begin
            for (int i = 0; i < 4; i++) begin
                if (lanes_q[i]) begin
                    pio[8*i +: 8] <= bus.hwdata[8*i +: 8];
                end
            end
        end
    end

    assign bus.hrdata     = '0;     // No read-back path.
    assign bus.hready_out = 1'b1;   // Always zero-wait.

endmodule

//--- source/ahb_pkg.sv
package ahb_pkg;

    // Bus widths. The address and both data buses are 32 bits wide.
    typedef logic [31:0] addr_t;    // Byte address on haddr.
    typedef logic [31:0] data_t;    // One word on hwdata or hrdata.
    typedef logic [3:0]  strb_t;    // One enable bit per byte lane of data_t.
    typedef logic [3:0]  region_t;  // Address bits 31 to 28.

    // AHB transfer type. Only NONSEQ and SEQ carry a transfer.
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_t;

    // Transfer size. Anything wider than a word is not used on this bus.
    typedef enum logic [2:0] {
        HSIZE_BYTE = 3'b000,
        HSIZE_HALF = 3'b001,
        HSIZE_WORD = 3'b010
    } hsize_t;

    localparam region_t RAM_REGION = 4'h8;  // On-chip RAM at 0x8xxx_xxxx.
    localparam region_t PIO_REGION = 4'hF;  // Parallel output at 0xFxxx_xxxx.

    localparam logic HRESP_OKAY = 1'b0;     // The only response this bus gives.

    // Byte lanes touched by a transfer of the given size at the given low address bits.
    // A byte picks one lane, a halfword picks the lower or upper pair and a word picks all.
    function automatic strb_t byte_lanes(hsize_t size, logic [1:0] addr_lo);
        strb_t lanes;
        case (size)
            HSIZE_BYTE: lanes = strb_t'(4'b0001 << addr_lo);
            HSIZE_HALF: lanes = addr_lo[1] ? 4'b1100 : 4'b0011;
            default:    lanes = 4'b1111;    // Word size.
        endcase
        return lanes;
    endfunction

endpackage

//--- source/ahb_ram.sv
`timescale 1ns/1ns

// Zero-wait RAM slave.
// The address phase is captured in registers and the data phase acts on the word array.
// Reads come straight from the array through the captured word address, so a read right
// after a write to the same word sees the new data.
module ahb_ram import ahb_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 14   // Byte-address bits decoded by the RAM.
) (
    input logic      clk,
    input logic      reset,
    ahb_slave_if.slave bus
);

    localparam int WORD_ADDR_WIDTH = RAM_ADDR_WIDTH - 2;   // Two low bits select the byte.
    localparam int DEPTH           = 1 << WORD_ADDR_WIDTH;  // Words in the array.

    data_t mem [DEPTH];     // The storage itself.

    logic                       accept;     // An address phase for this slave this cycle.
    logic                       valid_q;    // A captured transfer is in its data phase.
    logic                       write_q;    // The captured transfer is a write.
    logic [WORD_ADDR_WIDTH-1:0] word_addr_q;
    strb_t                      lanes_q;    // Byte lanes of the captured transfer.

    // Selected, active and on a ready edge.
    assign accept = bus.hsel
                 && ((bus.htrans == HTRANS_NONSEQ) || (bus.htrans == HTRANS_SEQ))
                 && bus.hready_in;

    // Set for the data phase that follows an accepted address phase.
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (bus.hready_in) begin
            valid_q <= accept;  // Only moves on a ready edge, so a stretched phase holds.
        end
    end

    // Address-phase payload, taken on every ready edge.
    always_ff @(posedge clk) begin
        if (bus.hready_in) begin
            word_addr_q <= bus.haddr[RAM_ADDR_WIDTH-1:2];
            write_q     <= bus.hwrite;
            lanes_q     <= byte_lanes(bus.hsize, bus.haddr[1:0]);
        end
    end

    // Write data lands at the edge that ends the data phase.
    always_ff @(posedge clk) begin
        if (valid_q && write_q && bus.hready_in) begin
            for (int i = 0; i < 4; i++) begin
                if (lanes_q[i]) begin
                    mem[word_addr_q][8*i +: 8] <= bus.hwdata[8*i +: 8];    // Enabled lane only.
                end
            end
        end
    end

    // Read data during a read data phase and zero otherwise.
    assign bus.hrdata = (valid_q && !write_q) ? mem[word_addr_q] : '0;

    assign bus.hready_out = 1'b1;   // The RAM never inserts wait states.

endmodule

//--- source/ahb_slave_if.sv
`timescale 1ns/1ns

// One slave's view of the AHB-Lite bus.
interface ahb_slave_if import ahb_pkg::*; ();

    logic    hsel;          // Decoded select for this slave, valid in the address phase.
    htrans_t htrans;        // Transfer type from the master.
    hsize_t  hsize;         // Transfer size from the master.
    logic    hwrite;        // High for a write.
    addr_t   haddr;         // Full byte address.
    data_t   hwdata;        // Write data, valid in the data phase.
    logic    hready_in;     // Bus-wide ready. An edge with it high ends a phase.
    logic    hready_out;    // This slave's ready for its own data phase.
    data_t   hrdata;        // This slave's read data.

    // The interconnect drives the request side and reads the response.
    modport manager (
        output hsel, htrans, hsize, hwrite, haddr, hwdata, hready_in,
        input  hready_out, hrdata
    );

    // A slave sees the request and returns ready and read data.
    modport slave (
        input  hsel, htrans, hsize, hwrite, haddr, hwdata, hready_in,
        output hready_out, hrdata
    );

endinterface

//--- source/ahb_subsystem.sv
`timescale 1ns/1ns

// AHB-Lite memory and I/O subsystem.
// One master port feeds the interconnect, which serves the RAM at region 8 and the
// parallel output register at region F.
module ahb_subsystem import ahb_pkg::*; #(
    parameter int RAM_ADDR_WIDTH = 14   // 16 KB of RAM by default.
) (
    input  logic    clk,
    input  logic    reset,
    input  htrans_t htrans,
    input  hsize_t  hsize,
    input  logic    hwrite,
    input  addr_t   haddr,
    input  data_t   hwdata,
    output data_t   hrdata,
    output logic    hready,
    output logic    hresp,
    output data_t   pio
);

    ahb_slave_if ram_bus ();    // Interconnect to RAM.
    ahb_slave_if pio_bus ();    // Interconnect to PIO.

    ahb_interconnect u_interconnect (
        .clk     (clk),
        .reset   (reset),
        .htrans  (htrans),
        .hsize   (hsize),
        .hwrite  (hwrite),
        .haddr   (haddr),
        .hwdata  (hwdata),
        .hrdata  (hrdata),
        .hready  (hready),
        .hresp   (hresp),
        .ram_bus (ram_bus.manager),
        .pio_bus (pio_bus.manager)
    );

    ahb_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) u_ram (
        .clk   (clk),
        .reset (reset),
        .bus   (ram_bus.slave)
    );

    ahb_pio u_pio (
        .clk   (clk),
        .reset (reset),
        .bus   (pio_bus.slave),
        .pio   (pio)
    );

endmodule

//--- tests/ahb_subsystem_tb.sv
`timescale 1ns/1ns

// Self-checking testbench for the AHB-Lite subsystem.
// The initial block acts as the bus master, and a negedge process follows the data phases.
module ahb_subsystem_tb import ahb_pkg::*; ();

    localparam int RAM_ADDR_WIDTH = 14;                         // 16 KB of RAM.
    localparam int WORDS          = 1 << (RAM_ADDR_WIDTH - 2);  // Words in the model.
    localparam int READY_TIMEOUT  = 50;                         // Cycles allowed for hready.

    logic    clk;
    logic    reset;
    htrans_t htrans;
    hsize_t  hsize;
    logic    hwrite;
    addr_t   haddr;
    data_t   hwdata;
    data_t   hrdata;
    logic    hready;
    logic    hresp;
    data_t   pio;

    data_t  ref_mem [WORDS];    // Reference copy of the RAM.
    data_t  ref_pio;            // Reference copy of the output register.
    data_t  next_wdata;         // Write data owed to the transfer now in its address phase.
    integer seed;
    int     check_count = 0;
    int     error_count = 0;
    logic   dp_valid;           // The monitor's view of the current data phase.
    logic   dp_write;
    addr_t  dp_addr;
    hsize_t dp_size;
    addr_t  addr_list [8];      // Addresses used by the random word test.
    addr_t  a;

    ahb_subsystem #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) ahb_subsystem_inst (
        .clk    (clk),
        .reset  (reset),
        .htrans (htrans),
        .hsize  (hsize),
        .hwrite (hwrite),
        .haddr  (haddr),
        .hwdata (hwdata),
        .hrdata (hrdata),
        .hready (hready),
        .hresp  (hresp),
        .pio    (pio)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;     // 20 ns period.
    end

    // Lanes written by a transfer of the given size at the given low address bits.
    function automatic strb_t lanes_for(hsize_t size, logic [1:0] lo);
        strb_t lanes;
        for (int i = 0; i < 4; i++) begin
            case (size)
                HSIZE_BYTE: lanes[i] = (i == lo);           // Only the addressed byte.
                HSIZE_HALF: lanes[i] = ((i / 2) == lo[1]);  // Lower or upper pair.
                default:    lanes[i] = 1'b1;
            endcase
        end
        return lanes;
    endfunction

    // Merges a write into the reference RAM or the reference pio word.
    function automatic void model_write(addr_t addr, hsize_t size, data_t wdata);
        strb_t lanes;
        lanes = lanes_for(size, addr[1:0]);
        for (int i = 0; i < 4; i++) begin
            if (lanes[i] && addr[31:28] == RAM_REGION) begin
                ref_mem[addr[RAM_ADDR_WIDTH-1:2]][8*i +: 8] = wdata[8*i +: 8];
            end else if (lanes[i] && addr[31:28] == PIO_REGION) begin
                ref_pio[8*i +: 8] = wdata[8*i +: 8];
            end
        end
    endfunction

    // Expected read data. Only the RAM region gives anything but zero.
    function automatic data_t expected_read(addr_t addr);
        if (addr[31:28] == RAM_REGION) begin
            return ref_mem[addr[RAM_ADDR_WIDTH-1:2]];
        end
        return '0;
    endfunction

    task automatic check_data(data_t actual, data_t expected, addr_t addr);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t: hrdata for %h is %h, expected %h", $time, addr, actual,
                     expected);
        end
    endtask

    task automatic check_pio(data_t actual, data_t expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t: pio is %h, expected %h", $time, actual, expected);
        end
    endtask

    task automatic check_resp(logic actual, logic expected, string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t: %s is %b, expected %b", $time, what, actual, expected);
        end
    endtask

    // Waits for the edge that ends the current phase, then steps 2 ns past it.
    task automatic wait_for_ready();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (hready !== 1'b1 && cycles <= READY_TIMEOUT) begin
            cycles++;
            @(negedge clk);
        end
        if (cycles > READY_TIMEOUT) begin
            $display("Timeout at %0t: hready stayed low for %0d cycles", $time, cycles);
            $display("Simulation failed");
            $finish;
        end else begin
            @(posedge clk);
            #2;
        end
    endtask

    // Puts one address phase on the bus together with the previous transfer's write data.
    task automatic present_phase(htrans_t trans, hsize_t size, logic write, addr_t addr,
                                 data_t wdata);
        htrans     = trans;
        hsize      = size;
        hwrite     = write;
        haddr      = addr;
        hwdata     = next_wdata;   // Data phase of the transfer before this one.
        next_wdata = wdata;
        wait_for_ready();
    endtask

    task automatic post_write(hsize_t size, addr_t addr, data_t wdata);
        present_phase(HTRANS_NONSEQ, size, 1'b1, addr, wdata);
    endtask

    task automatic post_read(addr_t addr);
        present_phase(HTRANS_NONSEQ, HSIZE_WORD, 1'b0, addr, '0);
    endtask

    task automatic go_idle();
        present_phase(HTRANS_IDLE, HSIZE_WORD, 1'b0, '0, '0);
    endtask

    function automatic addr_t random_ram_addr();
        return 32'h8000_0000 | (($unsigned($random(seed)) % WORDS) << 2);
    endfunction

    // Monitor. Checks responses every cycle and each read at the end of its data phase.
    always @(negedge clk) begin
        if (reset) begin
            dp_valid = 1'b0;
        end else begin
            check_pio(pio, ref_pio);    // Compared before this cycle's write is merged.
            check_resp(hresp, HRESP_OKAY, "hresp");
            check_resp(hready, 1'b1, "hready");
            if (hready) begin
                if (dp_valid && !dp_write) check_data(hrdata, expected_read(dp_addr), dp_addr);
                if (dp_valid && dp_write) model_write(dp_addr, dp_size, hwdata);
                dp_valid = (htrans == HTRANS_NONSEQ) || (htrans == HTRANS_SEQ);
                dp_write = hwrite;  // The address phase now becomes the next data phase.
                dp_addr  = haddr;
                dp_size  = hsize;
            end
        end
    end

    initial begin
        seed       = 32'h726dd725;
        ref_pio    = '0;
        next_wdata = '0;
        dp_valid   = 1'b0;
        reset      = 1'b1;
        htrans     = HTRANS_IDLE;
        hsize      = HSIZE_WORD;
        hwrite     = 1'b0;
        haddr      = '0;
        hwdata     = '0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        check_pio(pio, '0);                     // Reset state of the subsystem.
        check_resp(hready, 1'b1, "hready after reset");
        check_resp(hresp, HRESP_OKAY, "hresp after reset");
        @(posedge clk);
        #2;

        // Random words written back to back, then read back to back.
        for (int i = 0; i < 8; i++) begin
            addr_list[i] = random_ram_addr();
            post_write(HSIZE_WORD, addr_list[i], $random(seed));
        end
        for (int i = 0; i < 8; i++) post_read(addr_list[i]);

        // Byte and halfword lanes on a known word, at the start and the top of the RAM.
        a = 32'h8000_0100;
        post_write(HSIZE_WORD, a, $random(seed));
        for (int k = 0; k < 4; k++) post_write(HSIZE_BYTE, a + k, $random(seed));
        post_read(a);
        post_write(HSIZE_HALF, a, $random(seed));
        post_write(HSIZE_HALF, a + 2, $random(seed));
        post_read(a);
        a = 32'h8000_3FFC;
        post_write(HSIZE_WORD, a, $random(seed));
        post_write(HSIZE_HALF, a + 2, $random(seed));
        post_write(HSIZE_BYTE, a + 1, $random(seed));
        post_read(a);

        // Read issued right behind a write to the same word sees the new data.
        a = 32'h8000_0200;
        post_write(HSIZE_WORD, a, $random(seed));
        post_read(a);
        post_write(HSIZE_BYTE, a + 1, $random(seed));
        post_read(a);
        post_write(HSIZE_HALF, a + 2, $random(seed));
        present_phase(HTRANS_SEQ, HSIZE_WORD, 1'b0, a, '0);    // SEQ acts as a single.

        // RAM word 0 has the same low address bits as the output register writes below.
        post_write(HSIZE_WORD, 32'h8000_0000, $random(seed));

        // Output register written with every size.
        post_write(HSIZE_WORD, 32'hF000_0000, $random(seed));
        post_write(HSIZE_BYTE, 32'hF000_0001, $random(seed));
        post_write(HSIZE_BYTE, 32'hF000_0003, $random(seed));
        post_write(HSIZE_HALF, 32'hF000_0002, $random(seed));
        go_idle();
        post_write(HSIZE_HALF, 32'hF000_0000, $random(seed));
        go_idle();

        // PIO and unmapped reads return zero and leave the RAM alone.
        post_read(32'hF000_0000);
        post_read(32'hF000_0004);
        post_read(32'h0000_0040);
        for (int i = 0; i < 8; i++) post_read(addr_list[i]);
        post_read(32'h8000_0100);
        post_read(32'h8000_0000);

        go_idle();  // Let the last data phase finish.
        go_idle();

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
